// File: alu.sv
// Arithmetic, logic and shift unit
`timescale 1ns/10ps

module alu (
	input  logic [cpu16_pkg::DATA_W-1:0] a,
	input  logic [cpu16_pkg::DATA_W-1:0] b,
	input  logic [2:0]                   op,
	output logic [cpu16_pkg::DATA_W-1:0] result,
	output cpu16_pkg::flags_t            flags
);

	logic [cpu16_pkg::DATA_W-1:0] sum;
	logic [cpu16_pkg::DATA_W-1:0] diff;
	logic [3:0]                   shamt;
	logic                         add_ovf;
	logic                         sub_ovf;

	assign shamt = b[3:0];
	assign sum = a + b;
	assign diff = a - b;

	// Signed overflow from operand and result sign bits
	assign add_ovf = (a[cpu16_pkg::DATA_W-1] == b[cpu16_pkg::DATA_W-1]) &&
		(sum[cpu16_pkg::DATA_W-1] != a[cpu16_pkg::DATA_W-1]);
	assign sub_ovf = (a[cpu16_pkg::DATA_W-1] != b[cpu16_pkg::DATA_W-1]) &&
		(diff[cpu16_pkg::DATA_W-1] != a[cpu16_pkg::DATA_W-1]);

	always_comb begin
		result = sum;
		flags.v = 1'b0;
		case (cpu16_pkg::opcode_e'({1'b0, op}))
			cpu16_pkg::ADD,
			cpu16_pkg::INC: begin
				result = sum;
				flags.v = add_ovf;
			end
			cpu16_pkg::SUB: begin
				result = diff;
				flags.v = sub_ovf;
			end
			cpu16_pkg::NAND: result = ~(a & b);
			cpu16_pkg::XOR:  result = a ^ b;
			cpu16_pkg::SRA:  result = $signed(a) >>> shamt;	// Sign fill
			cpu16_pkg::SRL:  result = a >> shamt;	// Zero fill
			cpu16_pkg::SLL:  result = a << shamt;
			default:         result = sum;
		endcase
		flags.z = (result == '0);
		flags.n = result[cpu16_pkg::DATA_W-1];
	end

endmodule

// File: branch_unit.sv
// Flags and next-PC logic
`timescale 1ns/10ps

module branch_unit (
	input  logic                         clk,
	input  logic                         rst_n,
	input  cpu16_pkg::ctrl_t             ctrl,
	input  cpu16_pkg::instr_t            instr,
	input  logic [cpu16_pkg::DATA_W-1:0] pc,
	input  cpu16_pkg::flags_t            alu_flags,
	input  logic [cpu16_pkg::DATA_W-1:0] ret_addr,
	output logic [cpu16_pkg::DATA_W-1:0] next_pc
);

	cpu16_pkg::flags_t            flags_q;
	logic                         taken;
	logic [cpu16_pkg::DATA_W-1:0] pc_inc;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			flags_q <= '0;
		end else if (!instr.r_fmt.opcode[3]) begin	// Only the eight ALU opcodes
			flags_q <= alu_flags;
		end
	end

	always_comb begin
		case (instr.b_fmt.cond)
			cpu16_pkg::EQ: taken = flags_q.z;
			cpu16_pkg::NE: taken = !flags_q.z;
			cpu16_pkg::LT: taken = flags_q.n;
			cpu16_pkg::GE: taken = !flags_q.n;
			cpu16_pkg::GT: taken = !flags_q.z && !flags_q.n;
			cpu16_pkg::LE: taken = flags_q.z || flags_q.n;
			cpu16_pkg::OV: taken = flags_q.v;
			default:       taken = 1'b1;	// TR
		endcase
	end

	assign pc_inc = pc + 1'b1;

	always_comb begin
		if (ctrl.rtrn)
			next_pc = ret_addr;
		else if (ctrl.call)
			next_pc = pc_inc + {{(cpu16_pkg::DATA_W-12){instr.j_fmt.off12[11]}},
				instr.j_fmt.off12};
		else if (ctrl.branch && taken)
			next_pc = pc_inc + {{(cpu16_pkg::DATA_W-9){instr.b_fmt.off9[8]}},
				instr.b_fmt.off9};
		else
			next_pc = pc_inc;
	end

	flow_onehot: assert property (@(posedge clk) disable iff (!rst_n)
		$onehot0({ctrl.call, ctrl.rtrn, ctrl.branch}))
		else $error("branch_unit: more than one PC redirect");

endmodule

// File: control_logic.sv
// Opcode decoder
`timescale 1ns/10ps

module control_logic (
	input  cpu16_pkg::opcode_e opcode,
	output cpu16_pkg::ctrl_t   ctrl
);

	always_comb begin
		ctrl = '0;
		ctrl.alu_op = opcode[2:0];	// ALU opcodes pass straight through
		case (opcode)
			cpu16_pkg::ADD,
			cpu16_pkg::SUB,
			cpu16_pkg::NAND,
			cpu16_pkg::XOR: begin
				ctrl.reg_write = 1'b1;
			end
			cpu16_pkg::INC: begin
				ctrl.reg_write = 1'b1;
				ctrl.alu_src = 1'b1;
				ctrl.sign_ext_sel = 1'b1;	// Signed 4-bit increment
			end
			cpu16_pkg::SRA,
			cpu16_pkg::SRL,
			cpu16_pkg::SLL: begin
				ctrl.reg_write = 1'b1;
				ctrl.alu_src = 1'b1;	// Shift amount from rt field
			end
			cpu16_pkg::LW: begin
				ctrl.data_reg = 1'b1;
				ctrl.mem_to_reg = 1'b1;
				ctrl.alu_src = 1'b1;
				ctrl.reg_write = 1'b1;
				ctrl.alu_op = 3'(cpu16_pkg::ADD);
			end
			cpu16_pkg::SW: begin
				ctrl.data_reg = 1'b1;
				ctrl.reg_to_mem = 1'b1;
				ctrl.alu_src = 1'b1;
				ctrl.reg_rt_src = 1'b1;	// Store data comes from rd
				ctrl.alu_op = 3'(cpu16_pkg::ADD);
			end
			cpu16_pkg::LHB,
			cpu16_pkg::LLB: begin
				ctrl.reg_rt_src = 1'b1;	// Old rd keeps its other byte
				ctrl.reg_write = 1'b1;
				ctrl.half_spec = opcode[0];
			end
			cpu16_pkg::B: ctrl.branch = 1'b1;
			cpu16_pkg::CALL: begin
				ctrl.call = 1'b1;
				ctrl.reg_to_mem = 1'b1;	// Push return address
				ctrl.reg_write = 1'b1;
				ctrl.alu_op = 3'(cpu16_pkg::SUB);	// SP - 1
			end
			cpu16_pkg::RET: begin
				ctrl.rtrn = 1'b1;
				ctrl.reg_write = 1'b1;
				ctrl.alu_op = 3'(cpu16_pkg::ADD);	// SP + 1
			end
			cpu16_pkg::ERR: ctrl.halt = 1'b1;
		endcase
	end

	// A single data port cannot load and store in one cycle
	mem_dir_check: assert #0 (!(ctrl.mem_to_reg && ctrl.reg_to_mem))
		else $error("control_logic: load and store decoded together");

endmodule

// File: cpu16.f
cpu16_pkg.sv
control_logic.sv
reg_file.sv
alu.sv
branch_unit.sv
cpu16_core.sv
cpu16_tb.sv

// File: cpu16_core.sv
// CPU16 single-cycle core
`timescale 1ns/10ps

module cpu16_core (
	input  logic                         clk,
	input  logic                         rst_n,
	input  logic [cpu16_pkg::DATA_W-1:0] instr,
	output logic [cpu16_pkg::DATA_W-1:0] pc,
	output logic [cpu16_pkg::DATA_W-1:0] dmem_addr,
	output logic [cpu16_pkg::DATA_W-1:0] dmem_wdata,
	output logic                         dmem_we,
	output logic                         dmem_re,
	input  logic [cpu16_pkg::DATA_W-1:0] dmem_rdata,
	output logic                         wb_valid,
	output logic [3:0]                   wb_reg,
	output logic [cpu16_pkg::DATA_W-1:0] wb_data,
	output logic                         halted
);

	cpu16_pkg::instr_t            cur;
	cpu16_pkg::ctrl_t             ctrl;
	cpu16_pkg::flags_t            alu_flags;
	logic                         started;	// First cycle out of reset done
	logic                         exec;
	logic [3:0]                   rd_addr_1;
	logic [3:0]                   rd_addr_2;
	logic [3:0]                   wr_addr;
	logic [cpu16_pkg::DATA_W-1:0] rd_data_1;
	logic [cpu16_pkg::DATA_W-1:0] rd_data_2;
	logic [cpu16_pkg::DATA_W-1:0] alu_b;
	logic [cpu16_pkg::DATA_W-1:0] alu_result;
	logic [cpu16_pkg::DATA_W-1:0] wr_data;
	logic [cpu16_pkg::DATA_W-1:0] pc_plus_1;
	logic [cpu16_pkg::DATA_W-1:0] next_pc;

	assign exec = started && !halted;

	// Idle cycles decode as ERR, so no strobe or state change gets out
	assign cur = exec ? instr : {cpu16_pkg::ERR, 12'h000};
	assign pc_plus_1 = pc + 1'b1;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			started <= 1'b0;
			halted <= 1'b0;
			pc <= '0;
		end else begin
			started <= 1'b1;
			if (exec) begin
				halted <= ctrl.halt;
				if (!ctrl.halt)
					pc <= next_pc;	// Holds at the ERR address
			end
		end
	end

	control_logic u_ctrl (
		.opcode (cur.r_fmt.opcode),
		.ctrl   (ctrl)
	);

	// Stack ops read SP, loads and stores read the data segment
	assign rd_addr_1 = (ctrl.call || ctrl.rtrn) ? cpu16_pkg::REG_SP :
		ctrl.data_reg ? cpu16_pkg::REG_DS : cur.r_fmt.rs;
	assign rd_addr_2 = ctrl.reg_rt_src ? cur.r_fmt.rd : cur.r_fmt.rt;
	assign wr_addr = (ctrl.call || ctrl.rtrn) ? cpu16_pkg::REG_SP : cur.r_fmt.rd;

	reg_file u_regs (
		.clk       (clk),
		.rst_n     (rst_n),
		.rd_addr_1 (rd_addr_1),
		.rd_addr_2 (rd_addr_2),
		.wr_addr   (wr_addr),
		.wr_en     (wb_valid),
		.wr_data   (wr_data),
		.rd_data_1 (rd_data_1),
		.rd_data_2 (rd_data_2)
	);

	always_comb begin
		if (ctrl.call || ctrl.rtrn)
			alu_b = 'd1;	// SP step
		else if (ctrl.alu_src && ctrl.data_reg)
			alu_b = {{(cpu16_pkg::DATA_W-8){1'b0}}, cur.i_fmt.imm8};
		else if (ctrl.alu_src && ctrl.sign_ext_sel)
			alu_b = {{(cpu16_pkg::DATA_W-4){cur.r_fmt.rt[3]}}, cur.r_fmt.rt};
		else if (ctrl.alu_src)
			alu_b = {{(cpu16_pkg::DATA_W-4){1'b0}}, cur.r_fmt.rt};
		else
			alu_b = rd_data_2;
	end

	alu u_alu (
		.a      (rd_data_1),
		.b      (alu_b),
		.op     (ctrl.alu_op),
		.result (alu_result),
		.flags  (alu_flags)
	);

	branch_unit u_branch (
		.clk       (clk),
		.rst_n     (rst_n),
		.ctrl      (ctrl),
		.instr     (cur),
		.pc        (pc),
		.alu_flags (alu_flags),
		.ret_addr  (dmem_rdata),	// Popped from SP + 1
		.next_pc   (next_pc)
	);

	// reg_rt_src with a write only happens for LHB and LLB
	always_comb begin
		if (ctrl.mem_to_reg)
			wr_data = dmem_rdata;
		else if (ctrl.reg_rt_src && ctrl.half_spec)
			wr_data = {rd_data_2[cpu16_pkg::DATA_W-1:8], cur.i_fmt.imm8};
		else if (ctrl.reg_rt_src)
			wr_data = {cur.i_fmt.imm8, rd_data_2[7:0]};
		else
			wr_data = alu_result;
	end

	assign dmem_addr = ctrl.call ? rd_data_1 : alu_result;	// CALL pushes at SP
	assign dmem_wdata = ctrl.call ? pc_plus_1 : rd_data_2;
	assign dmem_we = ctrl.reg_to_mem;
	assign dmem_re = ctrl.mem_to_reg || ctrl.rtrn;

	assign wb_valid = ctrl.reg_write && (wr_addr != 4'd0);
	assign wb_reg = wr_addr;
	assign wb_data = wr_data;

	halt_quiet: assert property (@(posedge clk) disable iff (!rst_n)
		halted |=> $stable(pc) && !dmem_we && !dmem_re && !wb_valid)
		else $error("cpu16_core: activity after halt");

endmodule

// File: cpu16_pkg.sv
// CPU16 shared types
package cpu16_pkg;

	localparam int DATA_W = 16;
	localparam logic [3:0] REG_DS = 4'd14;	// Data segment base for LW/SW
	localparam logic [3:0] REG_SP = 4'd15;	// Stack pointer for CALL/RET

	typedef enum logic [3:0] {
		ADD  = 4'h0,
		SUB  = 4'h1,
		NAND = 4'h2,
		XOR  = 4'h3,
		INC  = 4'h4,
		SRA  = 4'h5,
		SRL  = 4'h6,
		SLL  = 4'h7,
		LW   = 4'h8,
		SW   = 4'h9,
		LHB  = 4'ha,
		LLB  = 4'hb,
		B    = 4'hc,
		CALL = 4'hd,
		RET  = 4'he,
		ERR  = 4'hf
	} opcode_e;

	typedef enum logic [2:0] {
		EQ = 3'b000,
		LT = 3'b001,
		GT = 3'b010,
		OV = 3'b011,
		NE = 3'b100,
		GE = 3'b101,
		LE = 3'b110,
		TR = 3'b111
	} cond_e;

	typedef struct packed {
		opcode_e    opcode;
		logic [3:0] rd;
		logic [3:0] rs;
		logic [3:0] rt;
	} r_fmt_t;

	typedef struct packed {
		opcode_e    opcode;
		logic [3:0] rd;
		logic [7:0] imm8;
	} i_fmt_t;

	typedef struct packed {
		opcode_e    opcode;
		cond_e      cond;
		logic [8:0] off9;
	} b_fmt_t;

	typedef struct packed {
		opcode_e     opcode;
		logic [11:0] off12;
	} j_fmt_t;

	// One instruction word, four ways to read it
	typedef union packed {
		r_fmt_t r_fmt;
		i_fmt_t i_fmt;
		b_fmt_t b_fmt;
		j_fmt_t j_fmt;
	} instr_t;

	typedef struct packed {
		logic       data_reg;	// Port 1 reads R14
		logic       call;
		logic       rtrn;
		logic       branch;
		logic       mem_to_reg;
		logic       reg_to_mem;
		logic [2:0] alu_op;
		logic       alu_src;	// Immediate operand b
		logic       sign_ext_sel;
		logic       reg_rt_src;	// Port 2 reads rd instead of rt
		logic       reg_write;
		logic       half_spec;	// 0 LHB, 1 LLB
		logic       halt;
	} ctrl_t;

	typedef struct packed {
		logic z;
		logic n;
		logic v;
	} flags_t;

endpackage

// File: cpu16_tb.sv
// CPU16 trace testbench
`timescale 1ns/10ps

module cpu16_tb;

	typedef struct packed {
		logic [15:0] key;	// Register number or store address
		logic [15:0] val;
	} trace_event_t;

	logic        clk = 1'b0;
	logic        rst_n = 1'b0;
	logic [15:0] instr;
	logic [15:0] pc;
	logic [15:0] dmem_addr;
	logic [15:0] dmem_wdata;
	logic        dmem_we;
	logic        dmem_re;
	logic [15:0] dmem_rdata;
	logic        wb_valid;
	logic [3:0]  wb_reg;
	logic [15:0] wb_data;
	logic        halted;

	logic [15:0]  rom [0:65535];
	logic [15:0]  dmem [0:65535];
	trace_event_t w_q[$];
	trace_event_t s_q[$];
	logic [15:0]  halt_pc;
	bit           have_halt = 1'b0;
	bit           loaded = 1'b0;
	bit           read_chk = 1'b0;	// Core is past its idle cycle
	bit           trace_ok;
	int           wi = 0;
	int           si = 0;
	int           val_errs = 0;
	int           seq_errs = 0;

	always #10 clk = ~clk;	// 20 ns period

	cpu16_core uut (
		.clk        (clk),
		.rst_n      (rst_n),
		.instr      (instr),
		.pc         (pc),
		.dmem_addr  (dmem_addr),
		.dmem_wdata (dmem_wdata),
		.dmem_we    (dmem_we),
		.dmem_re    (dmem_re),
		.dmem_rdata (dmem_rdata),
		.wb_valid   (wb_valid),
		.wb_reg     (wb_reg),
		.wb_data    (wb_data),
		.halted     (halted)
	);

	// Both memories answer in the same cycle
	assign instr = rom[pc];
	assign dmem_rdata = dmem[dmem_addr];

	always @(posedge clk) begin
		if (rst_n && dmem_we === 1'b1)
			dmem[dmem_addr] <= dmem_wdata;
	end

	task automatic fill_memories();
		for (int i = 0; i < 65536; i++) begin
			rom[i] = 16'hf000 | (16'(i ^ (i >> 4)) & 16'h0fff);	// ERR everywhere else
			dmem[i] = 16'(i) ^ 16'ha5c3;
		end
	endtask

	task automatic load_trace(output bit ok);
		int          fd;
		int          code;
		int          c;
		logic [7:0]  tag;
		logic [15:0] a;
		logic [15:0] b;
		bit          done;
		ok = 1'b0;
		done = 1'b0;
		fd = $fopen("cpu16_trace.txt", "r");
		if (fd != 0) begin
			ok = 1'b1;
			while (!done) begin
				code = $fscanf(fd, " %c", tag);
				if (code != 1) begin
					done = 1'b1;
				end else if (tag == "#") begin
					c = $fgetc(fd);	// Skip the rest of a comment line
					while (c != "\n" && c != -1) begin
						c = $fgetc(fd);
					end
				end else begin
					code = $fscanf(fd, "%h %h", a, b);
					if (code != 2) begin
						$display("Malformed trace line with tag %c", tag);
						ok = 1'b0;
					end
					case (tag)
						"I": rom[a] = b;
						"M": dmem[a] = b;
						"W": w_q.push_back({a, b});
						"S": s_q.push_back({a, b});
						"H": begin
							halt_pc = a;
							have_halt = 1'b1;
						end
						default: begin
							$display("Unknown trace tag %c", tag);
							ok = 1'b0;
						end
					endcase
				end
			end
			$fclose(fd);
		end
	endtask

	task automatic check_write();
		trace_event_t want;
		if (wi >= w_q.size()) begin
			$display("Unexpected register write R%0d = %h at pc %h", wb_reg, wb_data, pc);
			seq_errs++;
		end else begin
			want = w_q[wi];
			if (wb_reg !== want.key[3:0] || wb_data !== want.val) begin
				$display("ERROR retire[%0d]: expected R%0d=%h, actual R%0d=%h",
					wi, want.key, want.val, wb_reg, wb_data);
				val_errs++;
			end
			wi++;
		end
	endtask

	task automatic check_store();
		trace_event_t want;
		if (si >= s_q.size()) begin
			$display("Unexpected store of %h to %h at pc %h", dmem_wdata, dmem_addr, pc);
			seq_errs++;
		end else begin
			want = s_q[si];
			if (dmem_addr !== want.key || dmem_wdata !== want.val) begin
				$display("ERROR store[%0d]: expected [%h]=%h, actual [%h]=%h",
					si, want.key, want.val, dmem_addr, dmem_wdata);
				val_errs++;
			end
			si++;
		end
	endtask

	// Only LW and RET read data memory
	task automatic check_read();
		logic want;
		want = (instr[15:12] == cpu16_pkg::LW || instr[15:12] == cpu16_pkg::RET);
		if (dmem_re !== want) begin
			$display("ERROR read_strobe: expected %b, actual %b at pc %h",
				want, dmem_re, pc);
			val_errs++;
		end
	endtask

	task automatic report_and_finish();
		$display("Errors: %0d value, %0d sequence", val_errs, seq_errs);
		if (val_errs + seq_errs == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	endtask

	// Events are sampled mid-cycle, away from the clock edge
	always @(negedge clk) begin
		if (rst_n === 1'b1 && loaded) begin
			if (wb_valid === 1'b1)
				check_write();
			if (dmem_we === 1'b1)
				check_store();
			if (read_chk)
				check_read();
		end
	end

	initial begin
		fill_memories();
		load_trace(trace_ok);
		if (!trace_ok) begin
			$display("Could not read a valid cpu16_trace.txt");
			seq_errs++;
			report_and_finish();
		end else begin
			loaded = 1'b1;
			repeat (8) @(posedge clk);
			rst_n <= 1'b1;
			@(negedge clk);
			if (pc !== 16'h0000) begin
				$display("ERROR reset_pc: expected 0000, actual %h", pc);
				val_errs++;
			end
			if (dmem_we !== 1'b0 || dmem_re !== 1'b0 || wb_valid !== 1'b0 ||
				halted !== 1'b0) begin
				$display("Strobes are not all low right after reset");
				seq_errs++;
			end
			read_chk <= 1'b1;
			wait (halted === 1'b1);
			@(negedge clk);
			if (!have_halt) begin
				$display("Trace gives no halt address");
				seq_errs++;
			end else if (pc !== halt_pc) begin
				$display("ERROR halt_pc: expected %h, actual %h", halt_pc, pc);
				val_errs++;
			end
			repeat (4) @(negedge clk);	// Nothing may retire while halted
			if (wi < w_q.size()) begin
				$display("%0d expected register writes never happened", w_q.size() - wi);
				seq_errs++;
			end
			if (si < s_q.size()) begin
				$display("%0d expected stores never happened", s_q.size() - si);
				seq_errs++;
			end
			report_and_finish();
		end
	end

	initial begin
		int limit;
		wait (loaded);
		limit = (w_q.size() + s_q.size() + 32) * 4;
		repeat (limit) @(posedge clk);
		$display("Watchdog: the core never halted within %0d cycles", limit);
		seq_errs++;
		report_and_finish();
	end

endmodule

// File: cpu16_trace.txt
# tag addr value: I rom word, M initial data word, H halt pc (value unused)
# tag key value: W expected write (register, data), S expected store (address, data)
I 0000 b1ff
I 0001 a17f
I 0002 420f
I 0003 1312
I 0004 5434
I 0005 6534
I 0006 7611
I 0007 0754
I 0008 2815
I 0009 3a12
I 000a 3011
I 000b c840
I 000c c240
I 000d c440
I 000e c640
I 000f c001
I 0010 b910
I 0011 ca01
I 0012 b912
I 0013 cc01
I 0014 b914
I 0015 ce01
I 0016 b916
I 0017 1012
I 0018 c040
I 0019 ca40
I 001a c801
I 001b b91b
I 001c c201
I 001d b91d
I 001e c601
I 001f b91f
I 0020 4b05
I 0021 cc40
I 0022 c401
I 0023 b923
I 0024 be40
I 0025 acbe
I 0026 bcef
I 0027 9c03
I 0028 8d03
I 0029 8105
I 002a bf80
I 002b d004
I 002c 4331
I 002d f000
I 0030 08bb
I 0031 e000
M 0045 1234
W 0001 00ff
W 0001 7fff
W 0002 ffff
W 0003 8000
W 0004 f800
W 0005 0800
W 0006 fffe
W 0007 0000
W 0008 f7ff
W 000a 8000
W 000b 0005
W 000e 0040
W 000c be00
W 000c beef
W 000d beef
W 0001 1234
W 000f 0080
W 000f 007f
W 0008 000a
W 000f 0080
W 0003 8001
S 0043 beef
S 0080 002c
H 002d 0000

// File: reg_file.sv
// Register file
`timescale 1ns/10ps

module reg_file (
	input  logic                         clk,
	input  logic                         rst_n,
	input  logic [3:0]                   rd_addr_1,
	input  logic [3:0]                   rd_addr_2,
	input  logic [3:0]                   wr_addr,
	input  logic                         wr_en,
	input  logic [cpu16_pkg::DATA_W-1:0] wr_data,
	output logic [cpu16_pkg::DATA_W-1:0] rd_data_1,
	output logic [cpu16_pkg::DATA_W-1:0] rd_data_2
);

	logic [cpu16_pkg::DATA_W-1:0] regs [16];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < 16; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en && wr_addr != 4'd0) begin
			regs[wr_addr] <= wr_data;
		end
	end

	// R0 is hardwired to zero
	assign rd_data_1 = (rd_addr_1 == 4'd0) ? '0 : regs[rd_addr_1];
	assign rd_data_2 = (rd_addr_2 == 4'd0) ? '0 : regs[rd_addr_2];

	wr_addr_known: assert property (@(posedge clk) disable iff (!rst_n)
		wr_en |-> !$isunknown(wr_addr))
		else $error("reg_file: write with unknown address");

endmodule
